/* ball_ctrl.sv */
/* Ball motion, speed and collisions. Paddle hits are caught while the
   frame is scanned and acted on at the next animate strobe. */

`timescale 1ns/1ps

module ball_ctrl (
    input  logic                  clk_pix,
    input  logic                  rst_n,
    input  pong_pkg::game_state_t state,
    scan_if.sink                  scan,
    sprite_if.ball                spr,
    output logic                  lft_col,
    output logic                  rgt_col
);
    import pong_pkg::*;

    coord_t   bx, by;
    logic     dx, dy;          // 0 is right / down
    speed_t   spx, spy;
    coord_t   spx_c, spy_c;    // speeds at coordinate width
    spd_cnt_t cnt_sp;          // paddle hits since last speed-up
    logic     p1_col, p2_col;  // ball touched a paddle this frame

    always_comb begin
        spx_c = coord_t'(spx);
        spy_c = coord_t'(spy);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (scan.animate) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (spr.b_draw) begin
            if (spr.p1_draw) p1_col <= 1'b1;
            if (spr.p2_draw) p2_col <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            spx    <= SPX_DEMO;
            spy    <= SPY_DEMO;
            cnt_sp <= '0;
        end else if (state == INIT) begin
            spx    <= SPX_DEMO;
            spy    <= SPY_DEMO;
            cnt_sp <= '0;
        end else if (state == START) begin
            spx    <= SPX_GAME;
            spy    <= SPY_GAME;
            cnt_sp <= '0;
        end else if (state == PLAY && scan.animate && (p1_col || p2_col)) begin
            if (cnt_sp == spd_cnt_t'(SPEED_STEP - 1)) begin
                if (spx != '1) spx <= spx + 1'b1;  // saturate at 15
                if (spy != '1) spy <= spy + 1'b1;
                cnt_sp <= '0;
            end else begin
                cnt_sp <= cnt_sp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            bx      <= BX_START;
            by      <= BY_START;
            dx      <= 1'b0;
            dy      <= 1'b0;
            lft_col <= 1'b0;
            rgt_col <= 1'b0;
        end else if (state == INIT || state == START) begin
            bx      <= BX_START;
            by      <= BY_START;
            dx      <= 1'b0;  // serve right
            dy      <= (state == START) ? ~dy : 1'b0;  // vertical serve varies with press time
            lft_col <= 1'b0;
            rgt_col <= 1'b0;
        end else if (scan.animate && state != POINT_END) begin
            if (p1_col) begin  // bounce off left paddle
                dx <= 1'b0;
                bx <= bx + spx_c;
            end else if (p2_col) begin  // bounce off right paddle
                dx <= 1'b1;
                bx <= bx - spx_c;
            end else if (bx >= H_RES - (spx_c + B_SIZE)) begin
                rgt_col <= 1'b1;
            end else if (bx < spx_c) begin
                lft_col <= 1'b1;
            end else begin
                bx <= dx ? bx - spx_c : bx + spx_c;
            end

            if (by >= V_RES - (spy_c + B_SIZE)) begin  // bottom edge
                dy <= 1'b1;
                by <= by - spy_c;
            end else if (by < spy_c) begin  // top edge
                dy <= 1'b0;
                by <= by + spy_c;
            end else begin
                by <= dy ? by - spy_c : by + spy_c;
            end
        end
    end

    assign spr.bx = bx;
    assign spr.by = by;

endmodule

/* debounce.sv */
/* Button debouncer. Level follows btn after DB_CYCLES stable samples plus
   the two synchroniser stages; release_pulse marks a 1 to 0 level change. */

`timescale 1ns/1ps

module debounce (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic btn,
    output logic level,
    output logic release_pulse
);
    import pong_pkg::*;

    logic    btn_meta, btn_sync;
    db_cnt_t cnt;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta      <= 1'b0;
            btn_sync      <= 1'b0;
            level         <= 1'b0;
            release_pulse <= 1'b0;
            cnt           <= '0;
        end else begin
            btn_meta      <= btn;
            btn_sync      <= btn_meta;
            release_pulse <= 1'b0;
            if (btn_sync == level) begin
                cnt <= '0;  // bounce back, start over
            end else if (cnt == db_cnt_t'(DB_CYCLES - 1)) begin
                level         <= btn_sync;
                release_pulse <= level;  // old level high means falling
                cnt           <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* display_timings.sv */
/* 640x480 scan counters for a 25 MHz class pixel clock.
   Sync, de and animate are decoded straight from the counters. */

`timescale 1ns/1ps

module display_timings (
    input  logic  clk_pix,
    input  logic  rst_n,
    scan_if.source scan
);
    import pong_pkg::*;

    coord_t sx, sy;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (sx == H_TOTAL - 10'd1) begin  // end of line
                sx <= '0;
                if (sy == V_TOTAL - 10'd1) begin
                    sy <= '0;
                end else begin
                    sy <= sy + 10'd1;
                end
            end else begin
                sx <= sx + 10'd1;
            end
        end
    end

    always_comb begin
        scan.sx      = sx;
        scan.sy      = sy;
        scan.hsync   = ~((sx >= H_SYNC_START) && (sx < H_SYNC_END));
        scan.vsync   = ~((sy >= V_SYNC_START) && (sy < V_SYNC_END));
        scan.de      = (sx < H_RES) && (sy < V_RES);
        scan.animate = (sy == V_RES) && (sx == '0);  // first blanking line
    end

    // counter never leaves the line
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        sx < H_TOTAL
    ) else $error("sx out of range: %0d", sx);

endmodule

/* filelist.f */
pong_pkg.sv
pong_if.sv
display_timings.sv
debounce.sv
game_fsm.sv
paddle_ctrl.sv
ball_ctrl.sv
sprite_render.sv
pong_core.sv
tb_pong.sv

/* game_fsm.sv */
/* Game flow. INIT runs a single cycle, then the demo in IDLE.
   Edge flags only matter in PLAY. */

`timescale 1ns/1ps

module game_fsm (
    input  logic                  clk_pix,
    input  logic                  rst_n,
    input  logic                  ctrl_pulse,
    input  logic                  lft_col,
    input  logic                  rgt_col,
    output pong_pkg::game_state_t state
);
    import pong_pkg::*;

    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            INIT:      state_next = IDLE;
            IDLE:      if (ctrl_pulse) state_next = START;
            START:     if (ctrl_pulse) state_next = PLAY;
            PLAY:      if (lft_col || rgt_col) state_next = POINT_END;  // ball out
            POINT_END: if (ctrl_pulse) state_next = START;  // serve again
            default:   state_next = INIT;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= INIT;
        end else begin
            state <= state_next;
        end
    end

    a_state_legal: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        state inside {INIT, IDLE, START, PLAY, POINT_END}
    ) else $error("illegal game state %0d", state);

endmodule

/* paddle_ctrl.sv */
/* Paddle positions, updated once per frame on animate.
   Paddle 1 is the player in PLAY, both paddles chase the ball otherwise. */

`timescale 1ns/1ps

module paddle_ctrl (
    input  logic                  clk_pix,
    input  logic                  rst_n,
    input  pong_pkg::game_state_t state,
    input  logic                  move_up,
    input  logic                  move_dn,
    scan_if.sink                  scan,
    sprite_if.paddle              spr
);
    import pong_pkg::*;

    coord_t p1y, p2y;

    // AI step with half a step of dead band around the ball centre
    function automatic coord_t ai_step(coord_t py, coord_t ball_y);
        coord_t p_mid, b_mid;
        p_mid = py + (P_H >> 1);
        b_mid = ball_y + (B_SIZE >> 1);
        if (p_mid + (P_SP >> 1) < b_mid) begin
            return (py + P_H + P_SP <= V_RES) ? py + P_SP : V_RES - P_H;
        end else if (p_mid > b_mid + (P_SP >> 1)) begin
            return (py >= P_SP) ? py - P_SP : '0;
        end
        return py;
    endfunction

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1y <= P_START;
            p2y <= P_START;
        end else if (state == INIT || state == START) begin  // re-centre
            p1y <= P_START;
            p2y <= P_START;
        end else if (scan.animate && state != POINT_END) begin
            if (state == PLAY) begin
                if (move_up && !move_dn) begin
                    p1y <= (p1y >= P_SP) ? p1y - P_SP : '0;
                end else if (move_dn && !move_up) begin
                    p1y <= (p1y + P_H + P_SP <= V_RES) ? p1y + P_SP : V_RES - P_H;
                end
            end else begin
                p1y <= ai_step(p1y, spr.by);
            end
            p2y <= ai_step(p2y, spr.by);
        end
    end

    assign spr.p1y = p1y;
    assign spr.p2y = p2y;

    a_paddle_on_screen: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (p1y <= V_RES - P_H) && (p2y <= V_RES - P_H)
    ) else $error("paddle off screen: p1y=%0d p2y=%0d", p1y, p2y);

endmodule

/* pong_core.sv */
/* Pong core on the pixel clock. Buttons are active high and asynchronous.
   No clock generation or video encoding here. */

`timescale 1ns/1ps

module pong_core (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic       btn_up,
    input  logic       btn_dn,
    input  logic       btn_ctrl,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       hsync,
    output logic       vsync,
    output logic       de
);
    import pong_pkg::*;

    scan_if   scan ();
    sprite_if spr ();

    logic        ctrl_pulse, move_up, move_dn;
    logic        lft_col, rgt_col;
    game_state_t state;

    display_timings display_timings_inst (.clk_pix, .rst_n, .scan(scan.source));

    debounce deb_ctrl (  // only the release matters
        .clk_pix, .rst_n, .btn(btn_ctrl), .level(), .release_pulse(ctrl_pulse)
    );
    debounce deb_up (
        .clk_pix, .rst_n, .btn(btn_up), .level(move_up), .release_pulse()
    );
    debounce deb_dn (
        .clk_pix, .rst_n, .btn(btn_dn), .level(move_dn), .release_pulse()
    );

    game_fsm game_fsm_inst (.clk_pix, .rst_n, .ctrl_pulse, .lft_col, .rgt_col, .state);

    paddle_ctrl paddle_ctrl_inst (
        .clk_pix, .rst_n, .state, .move_up, .move_dn,
        .scan(scan.sink), .spr(spr.paddle)
    );

    ball_ctrl ball_ctrl_inst (
        .clk_pix, .rst_n, .state, .scan(scan.sink), .spr(spr.ball), .lft_col, .rgt_col
    );

    sprite_render sprite_render_inst (
        .clk_pix, .rst_n, .scan(scan.sink), .spr(spr.render),
        .red, .green, .blue, .hsync, .vsync, .de
    );

endmodule

/* pong_if.sv */
/* Scan position bundle and sprite position/draw bundle.
   Draw flags are combinational and valid for the current sx, sy. */

`timescale 1ns/1ps

interface scan_if;
    import pong_pkg::*;

    coord_t sx;       // horizontal scan position
    coord_t sy;       // vertical scan position
    logic   de;       // active video
    logic   hsync;    // active low
    logic   vsync;    // active low
    logic   animate;  // one cycle at start of vertical blanking

    modport source (output sx, sy, de, hsync, vsync, animate);
    modport sink   (input  sx, sy, de, hsync, vsync, animate);
endinterface

interface sprite_if;
    import pong_pkg::*;

    coord_t bx, by;    // ball top left
    coord_t p1y, p2y;  // paddle top rows
    logic   b_draw, p1_draw, p2_draw;

    modport ball   (output bx, by, input b_draw, p1_draw, p2_draw);
    modport paddle (output p1y, p2y, input by);
    modport render (input bx, by, p1y, p2y, output b_draw, p1_draw, p2_draw);
endinterface

/* pong_pkg.sv */
/* Constants for a fixed 640x480 60 Hz mode with an 800x525 total frame.
   Values are not meant to be changed independently. */

package pong_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate
    typedef logic [3:0] speed_t;  // ball speed in pixels per frame

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        START,
        PLAY,
        POINT_END
    } game_state_t;

    // screen timing, both syncs active low
    localparam coord_t H_RES        = 10'd640;
    localparam coord_t V_RES        = 10'd480;
    localparam coord_t H_TOTAL      = 10'd800;
    localparam coord_t V_TOTAL      = 10'd525;
    localparam coord_t H_SYNC_START = 10'd656;
    localparam coord_t H_SYNC_END   = 10'd752;
    localparam coord_t V_SYNC_START = 10'd490;
    localparam coord_t V_SYNC_END   = 10'd492;

    localparam coord_t B_SIZE   = 10'd16;  // ball edge length
    localparam coord_t BX_START = (H_RES - B_SIZE) >> 1;
    localparam coord_t BY_START = (V_RES - B_SIZE) >> 1;

    localparam coord_t P_H     = 10'd64;  // paddle height
    localparam coord_t P_W     = 10'd15;  // paddle width
    localparam coord_t P_SP    = 10'd6;   // paddle step per frame
    localparam coord_t P_OFFS  = 10'd32;  // gap from screen edge
    localparam coord_t P_START = (V_RES - P_H) >> 1;

    localparam speed_t SPX_DEMO   = 4'd10;
    localparam speed_t SPY_DEMO   = 4'd6;
    localparam speed_t SPX_GAME   = 4'd5;
    localparam speed_t SPY_GAME   = 4'd3;
    localparam int     SPEED_STEP = 3;  // paddle hits per speed increase
    typedef logic [$clog2(SPEED_STEP)-1:0] spd_cnt_t;

    localparam int DB_CYCLES = 16;  // stable samples before a level is taken
    typedef logic [$clog2(DB_CYCLES)-1:0] db_cnt_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build tb_pong with Verilator and run it; exit status 1 on build error or test failure
verilator --binary --timing --assert -Wno-fatal --top-module tb_pong \
    -f filelist.f -o tb_pong > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_pong > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "test passed"

/* sprite_render.sv */
/* Monochrome renderer. All outputs are registered, so RGB lines up with
   the delayed syncs and de one cycle behind the scan counters. */

`timescale 1ns/1ps

module sprite_render (
    input  logic        clk_pix,
    input  logic        rst_n,
    scan_if.sink        scan,
    sprite_if.render    spr,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        hsync,
    output logic        vsync,
    output logic        de
);
    import pong_pkg::*;

    logic lit;  // pixel is white

    always_comb begin
        spr.b_draw  = (scan.sx >= spr.bx) && (scan.sx < spr.bx + B_SIZE)
                   && (scan.sy >= spr.by) && (scan.sy < spr.by + B_SIZE);
        spr.p1_draw = (scan.sx >= P_OFFS) && (scan.sx < P_OFFS + P_W)
                   && (scan.sy >= spr.p1y) && (scan.sy < spr.p1y + P_H);
        spr.p2_draw = (scan.sx >= H_RES - P_OFFS - P_W) && (scan.sx < H_RES - P_OFFS)
                   && (scan.sy >= spr.p2y) && (scan.sy < spr.p2y + P_H);
        lit = scan.de && (spr.b_draw || spr.p1_draw || spr.p2_draw);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;  // syncs idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= 8'h00;
            green <= 8'h00;
            blue  <= 8'h00;
        end else begin
            hsync <= scan.hsync;
            vsync <= scan.vsync;
            de    <= scan.de;
            red   <= lit ? 8'hFF : 8'h00;
            green <= lit ? 8'hFF : 8'h00;
            blue  <= lit ? 8'hFF : 8'h00;
        end
    end

endmodule

/* tb_pong.sv */
/* Testbench for pong_core. Output pixels are sampled on the falling clock edge
   into a small frame model, the assertions run on the rising edge.
   Stimulus covers reset, the IDLE to START to PLAY presses and btn_up held. */

`timescale 1ns/1ps

module tb_pong;

    localparam int H_VIS      = 640;
    localparam int H_PERIOD   = 800;
    localparam int H_PULSE    = 96;
    localparam int V_VIS      = 480;
    localparam int V_PERIOD   = 525;  // lines
    localparam int V_PULSE    = 2;    // lines
    localparam int MAX_CYCLES = 6_000_000;  // about 14 frames of 420000 cycles
    localparam int PRESS_LEN  = 40;
    localparam int BAND_LEFT  = 160;  // columns below belong to paddle 1
    localparam int BAND_RIGHT = 480;  // columns from here belong to paddle 2

    // white area as {x min, x max, y min, y max, pixel count}
    localparam logic [51:0] P1_HOME   = {10'd32, 10'd46, 10'd208, 10'd271, 12'd960};
    localparam logic [51:0] P2_HOME   = {10'd593, 10'd607, 10'd208, 10'd271, 12'd960};
    localparam logic [51:0] BALL_HOME = {10'd312, 10'd327, 10'd232, 10'd247, 12'd256};
    localparam logic [51:0] EMPTY     = {10'd1023, 10'd0, 10'd1023, 10'd0, 12'd0};

    logic       clk_pix, rst_n;
    logic       btn_up, btn_dn, btn_ctrl;
    logic [7:0] red, green, blue;
    logic       hsync, vsync, de;

    int cycles, seed;
    logic in_start, in_play;  // set by stimulus once the state is settled

    // frame model, updated on the falling edge
    logic             hs_q, vs_q, de_q, h_seen, v_seen;
    logic             hrise_ev, hfall_ev, vrise_ev, vfall_ev, defall_ev, frame_ev;
    int               h_cnt, h_meas, de_cnt, de_meas, row_cnt, rows_meas, vl_cnt, vl_meas;
    int               frame_idx;
    logic             pix_de;
    logic [23:0]      pix_rgb;
    logic [2:0][51:0] band, fr_band, prev_band;
    logic             start_cur, play_cur, play_prev;

    pong_core pong_core_inst (
        .clk_pix, .rst_n, .btn_up, .btn_dn, .btn_ctrl,
        .red, .green, .blue, .hsync, .vsync, .de
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    function automatic logic [51:0] area_add(logic [51:0] area, logic [9:0] x, logic [9:0] y);
        logic [9:0]  x0, x1, y0, y1;
        logic [11:0] n;
        {x0, x1, y0, y1, n} = area;
        if (x < x0) x0 = x;
        if (x > x1) x1 = x;
        if (y < y0) y0 = y;
        if (y > y1) y1 = y;
        return {x0, x1, y0, y1, n + 12'd1};
    endfunction

    function automatic string area_text(logic [51:0] a);
        return $sformatf("x %0d..%0d y %0d..%0d %0d px",
                         a[51:42], a[41:32], a[31:22], a[21:12], a[11:0]);
    endfunction

    task automatic report_mismatch(input string name, input string expected, input string actual);
        $display("[FAIL] %s expected %s actual %s", name, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "check %s failed", name);
    endtask

    always @(negedge clk_pix) begin : pixel_model
        logic [9:0] col;
        logic [9:0] row;
        int         b;
        col = de_q ? 10'(de_cnt) : 10'd0;
        row = de_q ? 10'(row_cnt - 1) : 10'(row_cnt);
        b   = (col < BAND_LEFT) ? 0 : ((col >= BAND_RIGHT) ? 2 : 1);
        if (!rst_n) begin
            {hs_q, vs_q, de_q, h_seen, v_seen} <= 5'b11000;
            {hrise_ev, hfall_ev, vrise_ev, vfall_ev, defall_ev, frame_ev} <= '0;
            {h_cnt, h_meas, de_cnt, de_meas, row_cnt, rows_meas, vl_cnt, vl_meas} <= '0;
            frame_idx <= 0;
            pix_de    <= 1'b0;
            pix_rgb   <= '0;
            band      <= {3{EMPTY}};
            fr_band   <= {3{EMPTY}};
            prev_band <= {3{EMPTY}};
            {start_cur, play_cur, play_prev} <= '0;
        end else begin
            {hs_q, vs_q, de_q} <= {hsync, vsync, de};
            pix_de  <= de;
            pix_rgb <= {red, green, blue};
            {hrise_ev, hfall_ev, vrise_ev, vfall_ev, defall_ev, frame_ev} <= '0;
            h_cnt <= h_cnt + 1;
            if (hs_q && !hsync) begin  // line sync starts
                h_cnt    <= 1;
                h_meas   <= h_cnt;
                hfall_ev <= h_seen;
                h_seen   <= 1'b1;
                vl_cnt   <= vl_cnt + 1;
            end
            if (!hs_q && hsync) begin
                h_meas   <= h_cnt;
                hrise_ev <= 1'b1;
            end
            if (de) begin
                de_cnt <= col + 1;
                if (!de_q) row_cnt <= row_cnt + 1;  // new visible line
                if ({red, green, blue} == 24'hFFFFFF) band[b] <= area_add(band[b], col, row);
            end
            if (de_q && !de) begin
                de_meas   <= de_cnt;
                defall_ev <= 1'b1;
            end
            if (vs_q && !vsync) begin  // frame done
                vl_meas   <= vl_cnt;
                vl_cnt    <= 0;
                vfall_ev  <= v_seen;
                v_seen    <= 1'b1;
                frame_ev  <= 1'b1;
                frame_idx <= frame_idx + 1;
                rows_meas <= row_cnt;
                row_cnt   <= 0;
                fr_band   <= band;
                prev_band <= fr_band;
                band      <= {3{EMPTY}};
                start_cur <= in_start;
                play_cur  <= in_play;
                play_prev <= play_cur;
            end
            if (!vs_q && vsync) begin
                vl_meas  <= vl_cnt;
                vrise_ev <= 1'b1;
            end
        end
    end

    a_hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hrise_ev |-> h_meas == H_PULSE)
        else report_mismatch("hsync_width", $sformatf("%0d", H_PULSE), $sformatf("%0d", h_meas));
    a_hsync_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        hfall_ev |-> h_meas == H_PERIOD)
        else report_mismatch("hsync_period", $sformatf("%0d", H_PERIOD), $sformatf("%0d", h_meas));
    a_vsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vrise_ev |-> vl_meas == V_PULSE)
        else report_mismatch("vsync_lines", $sformatf("%0d", V_PULSE), $sformatf("%0d", vl_meas));
    a_vsync_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vfall_ev |-> vl_meas == V_PERIOD)
        else report_mismatch("vsync_period", $sformatf("%0d", V_PERIOD), $sformatf("%0d", vl_meas));
    a_de_line: assert property (@(posedge clk_pix) disable iff (!rst_n)
        defall_ev |-> de_meas == H_VIS)
        else report_mismatch("de_per_line", $sformatf("%0d", H_VIS), $sformatf("%0d", de_meas));
    a_de_rows: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev |-> rows_meas == V_VIS)
        else report_mismatch("de_lines", $sformatf("%0d", V_VIS), $sformatf("%0d", rows_meas));
    a_rgb_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !pix_de |-> pix_rgb == 24'h000000)
        else report_mismatch("rgb_blank", "000000", $sformatf("%06h", pix_rgb));
    a_rgb_mono: assert property (@(posedge clk_pix) disable iff (!rst_n)
        pix_de |-> (pix_rgb == 24'h000000 || pix_rgb == 24'hFFFFFF))
        else report_mismatch("rgb_mono", "000000 or ffffff", $sformatf("%06h", pix_rgb));

    // first frame shows the reset positions
    a_frame1_p1: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && frame_idx == 1 |-> fr_band[0] == P1_HOME)
        else report_mismatch("frame1_paddle1", area_text(P1_HOME), area_text(fr_band[0]));
    a_frame1_ball: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && frame_idx == 1 |-> fr_band[1] == BALL_HOME)
        else report_mismatch("frame1_ball", area_text(BALL_HOME), area_text(fr_band[1]));
    a_frame1_p2: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && frame_idx == 1 |-> fr_band[2] == P2_HOME)
        else report_mismatch("frame1_paddle2", area_text(P2_HOME), area_text(fr_band[2]));
    a_start_ball: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && start_cur |-> fr_band[1] == BALL_HOME)
        else report_mismatch("start_ball", area_text(BALL_HOME), area_text(fr_band[1]));

    // PLAY with btn_up held, paddle 1 top row and ball left column per frame
    a_play_paddle: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && play_cur && play_prev |-> fr_band[0][31:22] == prev_band[0][31:22] - 10'd6)
        else report_mismatch("play_paddle1_top", $sformatf("%0d", prev_band[0][31:22] - 10'd6),
                             $sformatf("%0d", fr_band[0][31:22]));
    a_play_ball: assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame_ev && play_cur && play_prev |-> fr_band[1][51:42] == prev_band[1][51:42] + 10'd5)
        else report_mismatch("play_ball_left", $sformatf("%0d", prev_band[1][51:42] + 10'd5),
                             $sformatf("%0d", fr_band[1][51:42]));

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic wait_frames(input int n);
        repeat (n) begin
            @(posedge clk_pix);
            while (!frame_ev) @(posedge clk_pix);
        end
    endtask

    task automatic press_ctrl();
        int gap;
        gap = $random(seed) & 7;  // jitter of 1 to 8 cycles
        repeat (gap + 1) @(posedge clk_pix);
        btn_ctrl <= 1'b1;
        repeat (PRESS_LEN) @(posedge clk_pix);
        btn_ctrl <= 1'b0;
        repeat (30) @(posedge clk_pix);  // debounce latency plus the FSM step
    endtask

    initial begin
        seed     = 32'h6ae9f82a;
        cycles   = 0;
        rst_n    = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        btn_ctrl = 1'b0;
        in_start = 1'b0;
        in_play  = 1'b0;
        repeat (5) @(posedge clk_pix);
        rst_n <= 1'b1;
        wait_frames(1);  // frame 1 checked against the reset image
        press_ctrl();    // IDLE to START
        wait_frames(1);
        in_start <= 1'b1;
        wait_frames(1);
        in_start <= 1'b0;
        btn_up   <= 1'b1;
        press_ctrl();    // START to PLAY
        wait_frames(2);  // first frames after the switch are mixed
        in_play <= 1'b1;
        wait_frames(4);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
